//--- Makefile
SRCS := $(shell grep -v '^+' sources.f)

.PHONY: run clean

obj_dir/Vtb_gat_mem: sources.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_gat_mem -Mdir obj_dir -o Vtb_gat_mem

run: obj_dir/Vtb_gat_mem
	./obj_dir/Vtb_gat_mem 2>&1 | tee sim.log
	@if grep -q "Verification failed" sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/apb_map_pkg.sv
/* APB widths and region map. Region sits in paddr[15:12], word index in
   paddr[11:2]; byte offset bits are ignored. */

`default_nettype none

package apb_map_pkg;

  localparam int APB_ADDR_W = 16;
  localparam int APB_DATA_W = 32;

  // Address fields
  localparam int REGION_LSB = 12;
  localparam int INDEX_LSB  = 2;
  localparam int REGION_W   = APB_ADDR_W - REGION_LSB;
  localparam int INDEX_W    = REGION_LSB - INDEX_LSB;

  // Region codes
  localparam logic [REGION_W-1:0] REGION_H_DATA    = 4'd0;
  localparam logic [REGION_W-1:0] REGION_NODE_INFO = 4'd1;
  localparam logic [REGION_W-1:0] REGION_WEIGHT    = 4'd2;
  localparam logic [REGION_W-1:0] REGION_FEATURE   = 4'd3;

endpackage

`default_nettype wire

//--- design/apb_mem_loader.sv
/* APB slave, no wait states on writes, one on feature reads.
   H data, node info and weights are write only; features are read only. */

`default_nettype none

module apb_mem_loader (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        psel,
  input  logic                                        penable,
  input  logic                                        pwrite,
  input  logic [apb_map_pkg::APB_ADDR_W-1:0]          paddr,
  input  logic [apb_map_pkg::APB_DATA_W-1:0]          pwdata,
  output logic [apb_map_pkg::APB_DATA_W-1:0]          prdata,
  output logic                                        pready,
  output logic                                        pslverr,
  output logic                                        ps_h_data_ena,
  output logic [gat_dims_pkg::H_DATA_ADDR_W-1:0]      ps_h_data_addr,
  output logic [gat_dims_pkg::H_DATA_WIDTH-1:0]       ps_h_data_din,
  output logic                                        ps_node_info_ena,
  output logic [gat_dims_pkg::NODE_INFO_ADDR_W-1:0]   ps_node_info_addr,
  output logic [gat_dims_pkg::NODE_INFO_WIDTH-1:0]    ps_node_info_din,
  output logic                                        ps_wgt_ena,
  output logic [gat_dims_pkg::WEIGHT_ADDR_W-1:0]      ps_wgt_addr,
  output logic [gat_dims_pkg::DATA_WIDTH-1:0]         ps_wgt_din,
  output logic [gat_dims_pkg::NEW_FEATURE_ADDR_W-1:0] ps_feat_addr,
  input  logic [gat_dims_pkg::NEW_FEATURE_WIDTH-1:0]  feat_dout
);

  import gat_dims_pkg::*;
  import apb_map_pkg::*;

  logic [REGION_W-1:0] region;
  logic [INDEX_W-1:0]  index;
  logic                access;
  logic                in_range;
  logic                bad_dir;
  logic                err;
  logic                wr_ok;
  logic                rd_ok;
  logic                rd_wait;

  assign region = paddr[APB_ADDR_W-1:REGION_LSB];
  assign index  = paddr[REGION_LSB-1:INDEX_LSB];
  assign access = psel & penable;

  // ==========================================================================
  // Region decode and error check
  // ==========================================================================
  always_comb begin
    in_range = 1'b0;
    bad_dir  = 1'b0;
    case (region)
      REGION_H_DATA: begin
        in_range = (index < H_DATA_DEPTH);
        bad_dir  = !pwrite;
      end
      REGION_NODE_INFO: begin
        in_range = (index < NODE_INFO_DEPTH);
        bad_dir  = !pwrite;
      end
      REGION_WEIGHT: begin
        in_range = (index < WEIGHT_DEPTH);
        bad_dir  = !pwrite;
      end
      REGION_FEATURE: begin
        in_range = (index < NEW_FEATURE_DEPTH);
        bad_dir  = pwrite;
      end
      // Unmapped region stays out of range
      default: begin
        in_range = 1'b0;
      end
    endcase
  end

  assign err   = !in_range | bad_dir;
  assign wr_ok = access & pwrite & !err;
  assign rd_ok = access & !pwrite & !err;

  // ==========================================================================
  // Memory write strobes
  // ==========================================================================
  assign ps_h_data_ena     = wr_ok & (region == REGION_H_DATA);
  assign ps_h_data_addr    = index[H_DATA_ADDR_W-1:0];
  assign ps_h_data_din     = pwdata[H_DATA_WIDTH-1:0];

  assign ps_node_info_ena  = wr_ok & (region == REGION_NODE_INFO);
  assign ps_node_info_addr = index[NODE_INFO_ADDR_W-1:0];
  assign ps_node_info_din  = pwdata[NODE_INFO_WIDTH-1:0];

  assign ps_wgt_ena        = wr_ok & (region == REGION_WEIGHT);
  assign ps_wgt_addr       = index[WEIGHT_ADDR_W-1:0];
  assign ps_wgt_din        = pwdata[DATA_WIDTH-1:0];

  // ==========================================================================
  // Feature read with one wait state
  // ==========================================================================
  // Address goes out in the first access cycle, RAM output is ready in the next
  assign ps_feat_addr = index[NEW_FEATURE_ADDR_W-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_wait <= 1'b0;
    end else begin
      rd_wait <= rd_ok & !rd_wait;
    end
  end

  assign pready  = access & (err | pwrite | rd_wait);
  assign pslverr = access & err;
  assign prdata  = (rd_ok & rd_wait) ? APB_DATA_W'(feat_dout) : '0;

endmodule

`default_nettype wire

//--- design/feature_mem_bank.sv
/* New-feature memory. The active layer's conv block writes it,
   only the PS reads it back. */

`default_nettype none

module feature_mem_bank (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        gat_layer_reg,
  input  logic [gat_dims_pkg::NEW_FEATURE_WIDTH-1:0]  feat_din_conv1,
  input  logic                                        feat_ena_conv1,
  input  logic [gat_dims_pkg::NEW_FEATURE_ADDR_W-1:0] feat_addra_conv1,
  input  logic [gat_dims_pkg::NEW_FEATURE_WIDTH-1:0]  feat_din_conv2,
  input  logic                                        feat_ena_conv2,
  input  logic [gat_dims_pkg::NEW_FEATURE_ADDR_W-1:0] feat_addra_conv2,
  input  logic [gat_dims_pkg::NEW_FEATURE_ADDR_W-1:0] ps_feat_addr,
  output logic [gat_dims_pkg::NEW_FEATURE_WIDTH-1:0]  feat_dout
);

  import gat_dims_pkg::*;

  logic                          feat_ena;
  logic [NEW_FEATURE_ADDR_W-1:0] feat_addra;
  logic [NEW_FEATURE_WIDTH-1:0]  feat_din;

  // Writer follows the layer
  assign feat_ena   = gat_layer_reg ? feat_ena_conv2   : feat_ena_conv1;
  assign feat_addra = gat_layer_reg ? feat_addra_conv2 : feat_addra_conv1;
  assign feat_din   = gat_layer_reg ? feat_din_conv2   : feat_din_conv1;

  sdp_ram #(.DATA_W(NEW_FEATURE_WIDTH), .DEPTH(NEW_FEATURE_DEPTH)) u_feat_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .ena   (feat_ena),
    .addra (feat_addra),
    .din   (feat_din),
    .addrb (ps_feat_addr),
    .dout  (feat_dout)
  );

endmodule

`default_nettype wire

//--- design/gat_dims_pkg.sv
/* Graph and memory dimensions, scaled down for simulation.
   Changing a base count moves the derived widths and depths with it. */

`default_nettype none

package gat_dims_pkg;

  // ==========================================================================
  // Graph and feature sizes
  // ==========================================================================
  localparam int DATA_WIDTH        = 8;
  localparam int NUM_FEATURE_IN    = 30;
  localparam int NUM_FEATURE_OUT   = 16;
  localparam int TOTAL_NODES       = 256;
  localparam int MAX_NODES         = 16;
  localparam int NUM_SUBGRAPHS     = 32;

  // ==========================================================================
  // Memory words
  // ==========================================================================
  // H data word is the value with its column index on top
  localparam int COL_IDX_WIDTH     = $clog2(NUM_FEATURE_IN);
  localparam int H_DATA_WIDTH      = DATA_WIDTH + COL_IDX_WIDTH;
  localparam int H_DATA_DEPTH      = 1024;

  // Node info: row length, node count, flag
  localparam int NODE_INFO_WIDTH   = COL_IDX_WIDTH + $clog2(MAX_NODES) + 1;
  localparam int NODE_INFO_DEPTH   = TOTAL_NODES;

  localparam int WEIGHT_DEPTH      = NUM_FEATURE_OUT * (NUM_FEATURE_IN + 2);

  localparam int NEW_FEATURE_WIDTH = 32;
  localparam int NEW_FEATURE_DEPTH = NUM_SUBGRAPHS * NUM_FEATURE_OUT;

  // Address widths
  localparam int H_DATA_ADDR_W      = $clog2(H_DATA_DEPTH);
  localparam int NODE_INFO_ADDR_W   = $clog2(NODE_INFO_DEPTH);
  localparam int WEIGHT_ADDR_W      = $clog2(WEIGHT_DEPTH);
  localparam int NEW_FEATURE_ADDR_W = $clog2(NEW_FEATURE_DEPTH);

endpackage

`default_nettype wire

//--- design/gat_mem_top.sv
/* Shared memory block of the GAT accelerator: APB access for the PS,
   layer-selected ports for conv1 and conv2. Single clock domain. */

`default_nettype none

module gat_mem_top (
  input  logic                                        clk,
  input  logic                                        rst_n,
  // APB from the PS
  input  logic                                        psel,
  input  logic                                        penable,
  input  logic                                        pwrite,
  input  logic [apb_map_pkg::APB_ADDR_W-1:0]          paddr,
  input  logic [apb_map_pkg::APB_DATA_W-1:0]          pwdata,
  output logic [apb_map_pkg::APB_DATA_W-1:0]          prdata,
  output logic                                        pready,
  output logic                                        pslverr,
  // Layer control
  input  logic                                        gat_layer_reg,
  input  logic                                        new_feat_rdy,
  // conv2 feedback into H data
  input  logic [gat_dims_pkg::H_DATA_WIDTH-1:0]       h_data_din_conv2,
  input  logic                                        h_data_ena_conv2,
  input  logic [gat_dims_pkg::H_DATA_ADDR_W-1:0]      h_data_addra_conv2,
  // PL read ports
  input  logic [gat_dims_pkg::H_DATA_ADDR_W-1:0]      h_data_addrb_conv1,
  input  logic [gat_dims_pkg::H_DATA_ADDR_W-1:0]      h_data_addrb_conv2,
  input  logic [gat_dims_pkg::NODE_INFO_ADDR_W-1:0]   node_info_addrb_conv1,
  input  logic [gat_dims_pkg::NODE_INFO_ADDR_W-1:0]   node_info_addrb_conv2,
  input  logic [gat_dims_pkg::WEIGHT_ADDR_W-1:0]      wgt_addrb_conv1,
  input  logic [gat_dims_pkg::WEIGHT_ADDR_W-1:0]      wgt_addrb_conv2,
  output logic [gat_dims_pkg::H_DATA_WIDTH-1:0]       h_data_dout,
  output logic [gat_dims_pkg::NODE_INFO_WIDTH-1:0]    node_info_dout,
  output logic [gat_dims_pkg::DATA_WIDTH-1:0]         wgt_dout,
  // PL feature writes
  input  logic [gat_dims_pkg::NEW_FEATURE_WIDTH-1:0]  feat_din_conv1,
  input  logic                                        feat_ena_conv1,
  input  logic [gat_dims_pkg::NEW_FEATURE_ADDR_W-1:0] feat_addra_conv1,
  input  logic [gat_dims_pkg::NEW_FEATURE_WIDTH-1:0]  feat_din_conv2,
  input  logic                                        feat_ena_conv2,
  input  logic [gat_dims_pkg::NEW_FEATURE_ADDR_W-1:0] feat_addra_conv2
);

  import gat_dims_pkg::*;

  // Loader to bank wires
  logic                          ps_h_data_ena;
  logic [H_DATA_ADDR_W-1:0]      ps_h_data_addr;
  logic [H_DATA_WIDTH-1:0]       ps_h_data_din;
  logic                          ps_node_info_ena;
  logic [NODE_INFO_ADDR_W-1:0]   ps_node_info_addr;
  logic [NODE_INFO_WIDTH-1:0]    ps_node_info_din;
  logic                          ps_wgt_ena;
  logic [WEIGHT_ADDR_W-1:0]      ps_wgt_addr;
  logic [DATA_WIDTH-1:0]         ps_wgt_din;
  logic [NEW_FEATURE_ADDR_W-1:0] ps_feat_addr;
  logic [NEW_FEATURE_WIDTH-1:0]  feat_dout;

  // Port names match the wires one to one
  apb_mem_loader u_apb_mem_loader (.*);

  input_mem_bank u_input_mem_bank (.*);

  feature_mem_bank u_feature_mem_bank (.*);

endmodule

`default_nettype wire

//--- design/input_mem_bank.sv
/* H data, node info and weight memories. Layer 0 reads via conv1 ports,
   layer 1 via conv2; conv2 feedback takes the H write port from the PS. */

`default_nettype none

module input_mem_bank (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      gat_layer_reg,
  input  logic                                      new_feat_rdy,
  input  logic                                      ps_h_data_ena,
  input  logic [gat_dims_pkg::H_DATA_ADDR_W-1:0]    ps_h_data_addr,
  input  logic [gat_dims_pkg::H_DATA_WIDTH-1:0]     ps_h_data_din,
  input  logic                                      ps_node_info_ena,
  input  logic [gat_dims_pkg::NODE_INFO_ADDR_W-1:0] ps_node_info_addr,
  input  logic [gat_dims_pkg::NODE_INFO_WIDTH-1:0]  ps_node_info_din,
  input  logic                                      ps_wgt_ena,
  input  logic [gat_dims_pkg::WEIGHT_ADDR_W-1:0]    ps_wgt_addr,
  input  logic [gat_dims_pkg::DATA_WIDTH-1:0]       ps_wgt_din,
  input  logic [gat_dims_pkg::H_DATA_WIDTH-1:0]     h_data_din_conv2,
  input  logic                                      h_data_ena_conv2,
  input  logic [gat_dims_pkg::H_DATA_ADDR_W-1:0]    h_data_addra_conv2,
  input  logic [gat_dims_pkg::H_DATA_ADDR_W-1:0]    h_data_addrb_conv1,
  input  logic [gat_dims_pkg::H_DATA_ADDR_W-1:0]    h_data_addrb_conv2,
  input  logic [gat_dims_pkg::NODE_INFO_ADDR_W-1:0] node_info_addrb_conv1,
  input  logic [gat_dims_pkg::NODE_INFO_ADDR_W-1:0] node_info_addrb_conv2,
  input  logic [gat_dims_pkg::WEIGHT_ADDR_W-1:0]    wgt_addrb_conv1,
  input  logic [gat_dims_pkg::WEIGHT_ADDR_W-1:0]    wgt_addrb_conv2,
  output logic [gat_dims_pkg::H_DATA_WIDTH-1:0]     h_data_dout,
  output logic [gat_dims_pkg::NODE_INFO_WIDTH-1:0]  node_info_dout,
  output logic [gat_dims_pkg::DATA_WIDTH-1:0]       wgt_dout
);

  import gat_dims_pkg::*;

  logic                        feedback;
  logic                        h_ena;
  logic [H_DATA_ADDR_W-1:0]    h_addra;
  logic [H_DATA_WIDTH-1:0]     h_din;
  logic [H_DATA_ADDR_W-1:0]    h_addrb;
  logic [NODE_INFO_ADDR_W-1:0] node_info_addrb;
  logic [WEIGHT_ADDR_W-1:0]    wgt_addrb;

  // Read side follows the active layer
  assign h_addrb         = gat_layer_reg ? h_data_addrb_conv2    : h_data_addrb_conv1;
  assign node_info_addrb = gat_layer_reg ? node_info_addrb_conv2 : node_info_addrb_conv1;
  assign wgt_addrb       = gat_layer_reg ? wgt_addrb_conv2       : wgt_addrb_conv1;

  // Layer 1 input is written back by conv2, PS writes are dropped meanwhile
  assign feedback = new_feat_rdy & !gat_layer_reg;
  assign h_ena    = feedback ? h_data_ena_conv2   : ps_h_data_ena;
  assign h_addra  = feedback ? h_data_addra_conv2 : ps_h_data_addr;
  assign h_din    = feedback ? h_data_din_conv2   : ps_h_data_din;

  // ==========================================================================
  // Memories
  // ==========================================================================
  sdp_ram #(.DATA_W(H_DATA_WIDTH), .DEPTH(H_DATA_DEPTH)) u_h_data_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .ena   (h_ena),
    .addra (h_addra),
    .din   (h_din),
    .addrb (h_addrb),
    .dout  (h_data_dout)
  );

  sdp_ram #(.DATA_W(NODE_INFO_WIDTH), .DEPTH(NODE_INFO_DEPTH)) u_node_info_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .ena   (ps_node_info_ena),
    .addra (ps_node_info_addr),
    .din   (ps_node_info_din),
    .addrb (node_info_addrb),
    .dout  (node_info_dout)
  );

  sdp_ram #(.DATA_W(DATA_WIDTH), .DEPTH(WEIGHT_DEPTH)) u_wgt_ram (
    .clk   (clk),
    .rst_n (rst_n),
    .ena   (ps_wgt_ena),
    .addra (ps_wgt_addr),
    .din   (ps_wgt_din),
    .addrb (wgt_addrb),
    .dout  (wgt_dout)
  );

endmodule

`default_nettype wire

//--- design/sdp_ram.sv
/* One write port, one read port with a registered output.
   Read returns the old word when both ports hit the same address. */

`default_nettype none

module sdp_ram #(
  parameter int DATA_W = 8,
  parameter int DEPTH  = 256
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     ena,
  input  logic [$clog2(DEPTH)-1:0] addra,
  input  logic [DATA_W-1:0]        din,
  input  logic [$clog2(DEPTH)-1:0] addrb,
  output logic [DATA_W-1:0]        dout
);

  logic [DATA_W-1:0] mem [DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (ena) begin
      mem[addra] <= din;
    end
  end

  // Read port, one cycle latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dout <= '0;
    end else begin
      dout <= mem[addrb];
    end
  end

endmodule

`default_nettype wire

//--- sources.f
design/gat_dims_pkg.sv
design/apb_map_pkg.sv
design/sdp_ram.sv
design/apb_mem_loader.sv
design/input_mem_bank.sv
design/feature_mem_bank.sv
design/gat_mem_top.sv
verif/tb_clk_gen.sv
verif/gat_mem_props.sv
verif/gat_mem_checker.sv
verif/tb_gat_mem.sv

//--- verif/gat_mem_checker.sv
/* Shadow model of the four memories, fed from the observed DUT inputs.
   Only written words are compared; unwritten RAM contents are unknown. */

`default_nettype none

module gat_mem_checker (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic                                        psel,
  input  logic                                        penable,
  input  logic                                        pwrite,
  input  logic [15:0]                                 paddr,
  input  logic [31:0]                                 pwdata,
  input  logic [31:0]                                 prdata,
  input  logic                                        pready,
  input  logic                                        pslverr,
  input  logic                                        gat_layer_reg,
  input  logic                                        new_feat_rdy,
  input  logic [gat_dims_pkg::H_DATA_WIDTH-1:0]       h_data_din_conv2,
  input  logic                                        h_data_ena_conv2,
  input  logic [gat_dims_pkg::H_DATA_ADDR_W-1:0]      h_data_addra_conv2,
  input  logic [gat_dims_pkg::H_DATA_ADDR_W-1:0]      h_data_addrb_conv1,
  input  logic [gat_dims_pkg::H_DATA_ADDR_W-1:0]      h_data_addrb_conv2,
  input  logic [gat_dims_pkg::NODE_INFO_ADDR_W-1:0]   node_info_addrb_conv1,
  input  logic [gat_dims_pkg::NODE_INFO_ADDR_W-1:0]   node_info_addrb_conv2,
  input  logic [gat_dims_pkg::WEIGHT_ADDR_W-1:0]      wgt_addrb_conv1,
  input  logic [gat_dims_pkg::WEIGHT_ADDR_W-1:0]      wgt_addrb_conv2,
  input  logic [gat_dims_pkg::H_DATA_WIDTH-1:0]       h_data_dout,
  input  logic [gat_dims_pkg::NODE_INFO_WIDTH-1:0]    node_info_dout,
  input  logic [gat_dims_pkg::DATA_WIDTH-1:0]         wgt_dout,
  input  logic [gat_dims_pkg::NEW_FEATURE_WIDTH-1:0]  feat_din_conv1,
  input  logic                                        feat_ena_conv1,
  input  logic [gat_dims_pkg::NEW_FEATURE_ADDR_W-1:0] feat_addra_conv1,
  input  logic [gat_dims_pkg::NEW_FEATURE_WIDTH-1:0]  feat_din_conv2,
  input  logic                                        feat_ena_conv2,
  input  logic [gat_dims_pkg::NEW_FEATURE_ADDR_W-1:0] feat_addra_conv2,
  input  int                                          test_id,
  input  logic [31:0]                                 exp_data,
  input  logic                                        exp_err,
  input  logic                                        pl_check,
  input  logic [3:0]                                  pl_region,
  input  logic                                        test_done,
  output int                                          num_checks,
  output int                                          num_errors
);

  timeunit 1ns;
  timeprecision 100ps;

  import gat_dims_pkg::*;
  import apb_map_pkg::*;

  logic [H_DATA_WIDTH-1:0]      sh_h [H_DATA_DEPTH];
  logic [NODE_INFO_WIDTH-1:0]   sh_n [NODE_INFO_DEPTH];
  logic [DATA_WIDTH-1:0]        sh_w [WEIGHT_DEPTH];
  logic [NEW_FEATURE_WIDTH-1:0] sh_f [NEW_FEATURE_DEPTH];
  logic [3:0]                   region;
  logic [9:0]                   index;
  logic                         feedback;
  int                           errs_before;

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("Mismatch at %0t: test %0d %s got %h expected %h",
               $time, test_id, what, got, exp);
    end
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      num_checks  = 0;
      num_errors  = 0;
      errs_before = 0;
    end else begin
      region   = paddr[15:12];
      index    = paddr[11:2];
      feedback = new_feat_rdy && !gat_layer_reg;

      // ======================================================================
      // APB transfer ends this cycle
      // ======================================================================
      if (psel && penable && pready) begin
        compare("pslverr", 32'(pslverr), 32'(exp_err));
        if (!exp_err && !pwrite) begin
          compare("prdata", prdata, exp_data);
          compare("feature shadow", 32'(sh_f[index[8:0]]), exp_data);
        end
        if (!exp_err && pwrite) begin
          case (region)
            // Dropped while conv2 feeds H data
            REGION_H_DATA:    if (!feedback) sh_h[index] = pwdata[H_DATA_WIDTH-1:0];
            REGION_NODE_INFO: sh_n[index[7:0]] = pwdata[NODE_INFO_WIDTH-1:0];
            REGION_WEIGHT:    sh_w[index[8:0]] = pwdata[DATA_WIDTH-1:0];
            default: ;
          endcase
        end
      end

      // PL read outputs, addresses still held
      if (pl_check) begin
        case (pl_region)
          REGION_H_DATA: begin
            compare("h_data_dout", 32'(h_data_dout), exp_data);
            compare("h_data shadow", 32'(sh_h[gat_layer_reg ? h_data_addrb_conv2
                                                             : h_data_addrb_conv1]), exp_data);
          end
          REGION_NODE_INFO: begin
            compare("node_info_dout", 32'(node_info_dout), exp_data);
            compare("node_info shadow", 32'(sh_n[gat_layer_reg ? node_info_addrb_conv2
                                                                : node_info_addrb_conv1]),
                    exp_data);
          end
          default: begin
            compare("wgt_dout", 32'(wgt_dout), exp_data);
            compare("wgt shadow", 32'(sh_w[gat_layer_reg ? wgt_addrb_conv2 : wgt_addrb_conv1]),
                    exp_data);
          end
        endcase
      end

      // PL writes
      if (feedback && h_data_ena_conv2) sh_h[h_data_addra_conv2] = h_data_din_conv2;
      if (gat_layer_reg && feat_ena_conv2) sh_f[feat_addra_conv2] = feat_din_conv2;
      if (!gat_layer_reg && feat_ena_conv1) sh_f[feat_addra_conv1] = feat_din_conv1;

      if (test_done) begin
        $display("Test %0d: %s", test_id, (num_errors == errs_before) ? "ok" : "FAILED");
        errs_before = num_errors;
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/gat_mem_props.sv
/* APB timing properties, bound into every apb_mem_loader instance. */

`default_nettype none

module gat_mem_props (
  input logic clk,
  input logic rst_n,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input logic pready,
  input logic pslverr,
  input logic rd_wait
);

  timeunit 1ns;
  timeprecision 100ps;

  // No ready outside an access phase
  a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !(psel && penable) |-> !pready) else $error("pready high outside an access phase");

  a_err_ready: assert property (@(posedge clk) disable iff (!rst_n)
    pslverr |-> pready) else $error("pslverr without pready");

  // First access cycle of a good read is the wait state
  a_read_first: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable && !pwrite && !pslverr && !$past(penable)) |-> !pready)
    else $error("feature read completed without a wait state");

  // Good reads hold one wait state, then complete
  a_read_wait: assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable && !pwrite && !pslverr && !pready) |=> (pready && rd_wait))
    else $error("feature read did not complete after one wait state");

endmodule

bind apb_mem_loader gat_mem_props u_gat_mem_props (.*);

`default_nettype wire

//--- verif/tb_clk_gen.sv
/* 4 ns clock, reset low for the first 3 rising edges. */

`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- verif/tb_gat_mem.sv
/* Table driven testbench for APB loads and reads, PL reads and writes, feedback.
   Stimulus changes on the falling edge; watchdog bounds the run. */

`default_nettype none

module tb_gat_mem;

  timeunit 1ns;
  timeprecision 100ps;

  import gat_dims_pkg::*;
  import apb_map_pkg::*;

  localparam int NUM_TESTS  = 28;
  localparam int OP_APB_WR  = 0;
  localparam int OP_APB_RD  = 1;
  localparam int OP_PL_RD   = 2;
  localparam int OP_FEAT_WR = 3;
  localparam int OP_FB_WR   = 4;

  logic clk, rst_n, psel, penable, pwrite, pready, pslverr;
  logic [15:0] paddr;
  logic [31:0] pwdata, prdata;
  logic gat_layer_reg, new_feat_rdy, h_data_ena_conv2, feat_ena_conv1, feat_ena_conv2;
  logic [H_DATA_WIDTH-1:0]       h_data_din_conv2, h_data_dout;
  logic [H_DATA_ADDR_W-1:0]      h_data_addra_conv2, h_data_addrb_conv1, h_data_addrb_conv2;
  logic [NODE_INFO_ADDR_W-1:0]   node_info_addrb_conv1, node_info_addrb_conv2;
  logic [WEIGHT_ADDR_W-1:0]      wgt_addrb_conv1, wgt_addrb_conv2;
  logic [NODE_INFO_WIDTH-1:0]    node_info_dout;
  logic [DATA_WIDTH-1:0]         wgt_dout;
  logic [NEW_FEATURE_WIDTH-1:0]  feat_din_conv1, feat_din_conv2;
  logic [NEW_FEATURE_ADDR_W-1:0] feat_addra_conv1, feat_addra_conv2;
  int          test_id, num_checks, num_errors, n_add, seed;
  logic [31:0] exp_data;
  logic        exp_err, pl_check, test_done;
  logic [3:0]  pl_region;
  logic [31:0] d [10];

  // ==========================================================================
  // Stimulus table
  // ==========================================================================
  int          t_op   [NUM_TESTS];
  logic [3:0]  t_reg  [NUM_TESTS];
  int          t_idx  [NUM_TESTS];
  logic [31:0] t_data [NUM_TESTS];
  logic        t_layer[NUM_TESTS];
  logic        t_rdy  [NUM_TESTS];
  logic [31:0] t_exp  [NUM_TESTS];
  logic        t_err  [NUM_TESTS];

  tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));
  gat_mem_top dut (.*);
  gat_mem_checker u_checker (.*);

  task automatic add_test(input int op, input logic [3:0] rg, input int idx,
                          input logic [31:0] data, input logic layer, input logic rdy,
                          input logic [31:0] exp, input logic err);
    t_op[n_add]    = op;
    t_reg[n_add]   = rg;
    t_idx[n_add]   = idx;
    t_data[n_add]  = data;
    t_layer[n_add] = layer;
    t_rdy[n_add]   = rdy;
    t_exp[n_add]   = exp;
    t_err[n_add]   = err;
    n_add++;
  endtask

  function automatic logic [31:0] mask_to(input logic [31:0] x, input int w);
    return x & ((32'd1 << w) - 32'd1);
  endfunction

  task automatic build_table();
    seed  = 46;
    n_add = 0;
    for (int i = 0; i < 10; i++) d[i] = $random(seed);
    // PS loads with decoy words at index 6
    add_test(OP_APB_WR, REGION_H_DATA,    5, d[0], 0, 0, 0, 0);
    add_test(OP_APB_WR, REGION_H_DATA,    6, d[1], 0, 0, 0, 0);
    add_test(OP_APB_WR, REGION_NODE_INFO, 5, d[2], 0, 0, 0, 0);
    add_test(OP_APB_WR, REGION_NODE_INFO, 6, d[3], 0, 0, 0, 0);
    add_test(OP_APB_WR, REGION_WEIGHT,    5, d[4], 0, 0, 0, 0);
    add_test(OP_APB_WR, REGION_WEIGHT,    6, d[5], 0, 0, 0, 0);
    add_test(OP_PL_RD, REGION_H_DATA,    5, 0, 0, 0, mask_to(d[0], H_DATA_WIDTH), 0);
    add_test(OP_PL_RD, REGION_NODE_INFO, 5, 0, 0, 0, mask_to(d[2], NODE_INFO_WIDTH), 0);
    add_test(OP_PL_RD, REGION_WEIGHT,    5, 0, 0, 0, mask_to(d[4], DATA_WIDTH), 0);
    add_test(OP_PL_RD, REGION_H_DATA,    6, 0, 1, 0, mask_to(d[1], H_DATA_WIDTH), 0);
    add_test(OP_PL_RD, REGION_NODE_INFO, 6, 0, 1, 0, mask_to(d[3], NODE_INFO_WIDTH), 0);
    add_test(OP_PL_RD, REGION_WEIGHT,    6, 0, 1, 0, mask_to(d[5], DATA_WIDTH), 0);
    add_test(OP_FEAT_WR, REGION_FEATURE, 10, d[6], 0, 0, 0, 0);
    add_test(OP_FEAT_WR, REGION_FEATURE, 11, d[7], 1, 0, 0, 0);
    add_test(OP_APB_RD, REGION_FEATURE, 10, 0, 0, 0, d[6], 0);
    add_test(OP_APB_RD, REGION_FEATURE, 11, 0, 0, 0, d[7], 0);
    // Feedback wins over the PS write to index 6
    add_test(OP_FB_WR, REGION_H_DATA, 5, d[8], 0, 1, 0, 0);
    add_test(OP_PL_RD, REGION_H_DATA, 5, 0, 0, 0, mask_to(d[8], H_DATA_WIDTH), 0);
    add_test(OP_PL_RD, REGION_H_DATA, 6, 0, 0, 0, mask_to(d[1], H_DATA_WIDTH), 0);
    // Error kinds aimed at aliases of written words where the index wraps
    add_test(OP_APB_WR, 4'd5,             5,   d[9], 0, 0, 0, 1);
    add_test(OP_APB_WR, REGION_WEIGHT,    517, d[9], 0, 0, 0, 1);
    add_test(OP_APB_WR, REGION_NODE_INFO, 261, d[9], 0, 0, 0, 1);
    add_test(OP_APB_WR, REGION_FEATURE,   10,  d[9], 0, 0, 0, 1);
    add_test(OP_APB_RD, REGION_H_DATA,    5,   0,    0, 0, 0, 1);
    add_test(OP_APB_RD, REGION_FEATURE,   600, 0,    0, 0, 0, 1);
    add_test(OP_APB_RD, REGION_FEATURE,   10,  0,    0, 0, d[6], 0);
    add_test(OP_PL_RD, REGION_WEIGHT,    5, 0, 0, 0, mask_to(d[4], DATA_WIDTH), 0);
    add_test(OP_PL_RD, REGION_NODE_INFO, 5, 0, 0, 0, mask_to(d[2], NODE_INFO_WIDTH), 0);
  endtask

  task automatic init_inputs();
    {psel, penable, pwrite, paddr, pwdata} = '0;
    {gat_layer_reg, new_feat_rdy, h_data_ena_conv2, h_data_din_conv2} = '0;
    {h_data_addra_conv2, h_data_addrb_conv1, h_data_addrb_conv2} = '0;
    {node_info_addrb_conv1, node_info_addrb_conv2, wgt_addrb_conv1, wgt_addrb_conv2} = '0;
    {feat_ena_conv1, feat_din_conv1, feat_addra_conv1} = '0;
    {feat_ena_conv2, feat_din_conv2, feat_addra_conv2} = '0;
    {test_id, exp_data, exp_err, pl_check, pl_region, test_done} = '0;
  endtask

  // Setup phase first, then access until the slave is ready
  task automatic apb_access(input logic wr, input logic [3:0] rg, input int idx,
                            input logic [31:0] data, input logic fb);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = {rg, 10'(idx), 2'b00};
    pwdata  = data;
    @(negedge clk);
    penable          = 1'b1;
    h_data_ena_conv2 = fb;
    @(posedge clk);
    while (!pready) @(posedge clk);
    @(negedge clk);
    {psel, penable, pwrite, h_data_ena_conv2} = '0;
  endtask

  task automatic pl_read(input logic [3:0] rg, input int idx);
    int other;
    other = idx ^ 3;
    h_data_addrb_conv1    = 10'(gat_layer_reg ? other : idx);
    node_info_addrb_conv1 = 8'(gat_layer_reg ? other : idx);
    wgt_addrb_conv1       = 9'(gat_layer_reg ? other : idx);
    h_data_addrb_conv2    = 10'(gat_layer_reg ? idx : other);
    node_info_addrb_conv2 = 8'(gat_layer_reg ? idx : other);
    wgt_addrb_conv2       = 9'(gat_layer_reg ? idx : other);
    @(negedge clk);
    pl_region = rg;
    pl_check  = 1'b1;
    @(negedge clk);
    pl_check = 1'b0;
  endtask

  task automatic run_test(input int i);
    test_id       = i;
    exp_data      = t_exp[i];
    exp_err       = t_err[i];
    gat_layer_reg = t_layer[i];
    new_feat_rdy  = t_rdy[i];
    case (t_op[i])
      OP_APB_WR: apb_access(1'b1, t_reg[i], t_idx[i], t_data[i], 1'b0);
      OP_APB_RD: apb_access(1'b0, t_reg[i], t_idx[i], t_data[i], 1'b0);
      OP_PL_RD:  pl_read(t_reg[i], t_idx[i]);
      OP_FEAT_WR: begin
        // The idle conv port offers another word at another index
        feat_addra_conv1 = 9'(t_layer[i] ? t_idx[i] ^ 3 : t_idx[i]);
        feat_addra_conv2 = 9'(t_layer[i] ? t_idx[i] : t_idx[i] ^ 3);
        feat_din_conv1   = t_layer[i] ? ~t_data[i] : t_data[i];
        feat_din_conv2   = t_layer[i] ? t_data[i] : ~t_data[i];
        feat_ena_conv1 = !t_layer[i];
        feat_ena_conv2 = t_layer[i];
        @(negedge clk);
        {feat_ena_conv1, feat_ena_conv2} = '0;
      end
      default: begin
        h_data_addra_conv2 = 10'(t_idx[i]);
        h_data_din_conv2   = t_data[i][H_DATA_WIDTH-1:0];
        apb_access(1'b1, REGION_H_DATA, t_idx[i] ^ 3, ~t_data[i], 1'b1);
      end
    endcase
    new_feat_rdy = 1'b0;
    test_done    = 1'b1;
    @(negedge clk);
    test_done = 1'b0;
  endtask

  initial begin
    init_inputs();
    build_table();
    wait (rst_n === 1'b1);
    @(negedge clk);
    for (int i = 0; i < NUM_TESTS; i++) run_test(i);
    repeat (2) @(negedge clk);
    $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, num_checks, num_errors);
    if (num_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Watchdog allows 12 cycles per test plus reset
  initial begin
    #((NUM_TESTS * 12 + 3) * 4);
    $display("Timeout: the tests did not finish in the allowed time");
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire
